// File: src.f
+incdir+common
common/fetch_pkg.sv
common/resolve_if.sv
branch_predictor/branch_predictor.sv
source/fetch_pc_gen.sv
source/fetch_queue.sv
source/fetch_top.sv
tests/fetch_checker.sv
tests/fetch_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the fetch testbench with Verilator, runs it and scans the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f src.f --top-module fetch_tb -o fetch_sim \
    && ./obj_dir/fetch_sim +verilator+error+limit+1000 > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1 || exit 0

// File: tests/fetch_tb.sv
`include "fetch_defs.svh"

module fetch_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import fetch_pkg::*;

    localparam int PERIOD            = 20;
    localparam int RESET_CYCLES      = 16;
    localparam int NUM_TESTS         = 6;
    localparam int MAX_PACKETS       = 240;  // random_mix checks 30 rounds of 8.
    localparam int CYCLES_PER_PACKET = 8;

    logic  clk;
    logic  reset;
    logic  redirect_valid;
    addr_t redirect_pc;
    logic  resolve_valid;
    addr_t resolve_pc;
    logic  resolve_taken;
    addr_t resolve_target;
    logic  out_valid;
    logic  out_ready;
    addr_t out_pc;
    logic  out_predict_taken;
    addr_t out_predict_target;

    logic [31:0] lfsr_state;
    int          test_count;
    int          check_count;
    int          error_count;

    // reference copy of the predictor state.
    int    model_count [`PRED_TABLE_SIZE];
    addr_t model_tag [`BTB_SIZE];
    addr_t model_target [`BTB_SIZE];

    fetch_top UUT (
        .clk                (clk),
        .reset              (reset),
        .redirect_valid     (redirect_valid),
        .redirect_pc        (redirect_pc),
        .resolve_valid      (resolve_valid),
        .resolve_pc         (resolve_pc),
        .resolve_taken      (resolve_taken),
        .resolve_target     (resolve_target),
        .out_valid          (out_valid),
        .out_ready          (out_ready),
        .out_pc             (out_pc),
        .out_predict_taken  (out_predict_taken),
        .out_predict_target (out_predict_target)
    );

    always #(PERIOD / 2) clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // random bits and reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // word aligned address made of base plus a random word offset.
    task automatic random_addr(input int bits, input addr_t base, output addr_t a);
        logic [31:0] r;
        take_bits(bits, r);
        a = base + {r[29:0], 2'b00};
    endtask

    function automatic int pht_index(input addr_t pc);
        return int'((pc >> 2) % `PRED_TABLE_SIZE);
    endfunction

    function automatic int btb_index(input addr_t pc);
        return int'((pc >> 2) % `BTB_SIZE);
    endfunction

    function automatic logic model_taken(input addr_t pc);
        return model_count[pht_index(pc)] >= 2;
    endfunction

    function automatic addr_t model_next(input addr_t pc);
        if (model_taken(pc) && model_tag[btb_index(pc)] == pc) begin
            return model_target[btb_index(pc)];
        end
        return pc + 32'd4;
    endfunction

    task automatic model_train(input addr_t pc, input logic taken, input addr_t target);
        int p;
        int b;
        p = pht_index(pc);
        b = btb_index(pc);
        if (taken) begin
            if (model_count[p] < 3) begin
                model_count[p]++;
            end
            model_tag[b]    = pc;
            model_target[b] = target;
        end else if (model_count[p] > 0) begin
            model_count[p]--;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus and checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic resolve(input addr_t pc, input logic taken, input addr_t target);
        @(posedge clk);
        #2;
        resolve_valid  = 1'b1;
        resolve_pc     = pc;
        resolve_taken  = taken;
        resolve_target = target;
        model_train(pc, taken, target);
    endtask

    task automatic redirect_to(input addr_t pc);
        @(posedge clk);
        #2;
        resolve_valid  = 1'b0;
        out_ready      = 1'b0;
        redirect_valid = 1'b1;
        redirect_pc    = pc;
        @(posedge clk);
        #2;
        redirect_valid = 1'b0;
    endtask

    task automatic compare_value(input string test, input string field,
                                 input addr_t expected, input addr_t actual);
        check_count++;
        assert (expected == actual) else begin
            $display("Error: %s %s expected %h actual %h", test, field, expected, actual);
            error_count++;
        end
    endtask

    // follows the predicted chain from start_pc over n accepted packets.
    task automatic check_packets(input string name, input addr_t start_pc, input int n);
        addr_t       expect_pc;
        addr_t       expect_target;
        logic        expect_taken;
        logic [31:0] r;
        int          got;
        expect_pc = start_pc;
        got = 0;
        while (got < n) begin
            @(posedge clk);
            #2;
            take_bits(2, r);
            out_ready = (r[1:0] != 2'b00);
            #1;
            if (out_valid && out_ready) begin
                expect_taken  = model_taken(expect_pc);
                expect_target = model_next(expect_pc);
                compare_value(name, "pc", expect_pc, out_pc);
                compare_value(name, "predict_taken", {31'd0, expect_taken},
                              {31'd0, out_predict_taken});
                compare_value(name, "predict_target", expect_target, out_predict_target);
                expect_pc = expect_target;
                got++;
            end
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        test_count++;
        $display("test %s done, %0d errors", name, error_count - errors_before);
    endtask

    initial begin
        repeat (RESET_CYCLES + NUM_TESTS * MAX_PACKETS * CYCLES_PER_PACKET) @(posedge clk);
        $display("timeout: the tests did not finish within the cycle budget");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        addr_t       pc;
        addr_t       target;
        logic [31:0] r;
        int          errors_before;
        int          resolves;
        clk            = 1'b0;
        reset          = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        resolve_valid  = 1'b0;
        resolve_pc     = '0;
        resolve_taken  = 1'b0;
        resolve_target = '0;
        out_ready      = 1'b0;
        lfsr_state     = 32'h13e2_42e8;
        test_count     = 0;
        check_count    = 0;
        error_count    = 0;
        for (int i = 0; i < `PRED_TABLE_SIZE; i++) begin
            model_count[i] = 1;
        end
        for (int j = 0; j < `BTB_SIZE; j++) begin
            model_tag[j]    = '0;
            model_target[j] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset = 1'b0;

        errors_before = error_count;
        check_packets("cold_start", `RESET_PC, 20);
        finish_test("cold_start", errors_before);

        errors_before = error_count;
        random_addr(30, '0, pc);
        random_addr(30, '0, target);
        repeat (2) resolve(pc, 1'b1, target);
        redirect_to(pc);
        check_packets("training", pc, 4);
        finish_test("training", errors_before);

        errors_before = error_count;
        random_addr(30, '0, pc);
        random_addr(30, '0, target);
        repeat (4) resolve(pc, 1'b1, target);
        resolve(pc, 1'b0, target);
        redirect_to(pc);
        check_packets("hysteresis", pc, 4);
        repeat (2) resolve(pc, 1'b0, target);
        redirect_to(pc);
        check_packets("hysteresis", pc, 4);
        finish_test("hysteresis", errors_before);

        // bit 16 lies above both index fields, so only the tag differs.
        errors_before = error_count;
        random_addr(30, '0, pc);
        random_addr(30, '0, target);
        repeat (2) resolve(pc, 1'b1, target);
        redirect_to(pc ^ 32'h0001_0000);
        check_packets("tag_mismatch", pc ^ 32'h0001_0000, 4);
        finish_test("tag_mismatch", errors_before);

        errors_before = error_count;
        random_addr(30, '0, pc);
        @(posedge clk);
        #2;
        out_ready = 1'b0;
        repeat (`FETCH_QUEUE_DEPTH + 3) @(posedge clk);
        #3;
        assert (out_valid) else begin
            $display("redirect_flush: no packet was waiting before the redirect");
            error_count++;
        end
        redirect_to(pc);
        check_packets("redirect_flush", pc, 6);
        finish_test("redirect_flush", errors_before);

        // a 1 KiB region, so counters and target entries alias often.
        errors_before = error_count;
        for (int round = 0; round < 30; round++) begin
            take_bits(2, r);
            resolves = int'(r[1:0]) + 1;
            for (int k = 0; k < resolves; k++) begin
                random_addr(8, 32'h0000_2000, pc);
                random_addr(8, 32'h0000_2000, target);
                take_bits(2, r);
                resolve(pc, r[1:0] != 2'b00, target);
            end
            redirect_to(pc);
            check_packets("random_mix", pc, 8);
        end
        finish_test("random_mix", errors_before);

        error_count += int'(UUT.protocol_check.failures);
        $display("tests %0d, checks %0d, errors %0d, protocol assertion failures %0d",
                 test_count, check_count, error_count, UUT.protocol_check.failures);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: tests/fetch_checker.sv
module fetch_checker (
    input logic             clk,
    input logic             reset,
    input logic             redirect_valid,
    input logic             out_valid,
    input logic             out_ready,
    input fetch_pkg::addr_t out_pc,
    input logic             out_predict_taken,
    input fetch_pkg::addr_t out_predict_target
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned failures = 0;

    // queue comes out of reset empty.
    reset_empties: assert property (@(posedge clk) reset |=> !out_valid)
        else begin
            $error("out_valid high in the cycle after reset");
            failures++;
        end

    // a waiting packet holds until decode takes it, unless a redirect drops it.
    packet_holds: assert property (@(posedge clk) disable iff (reset)
        (out_valid && !out_ready && !redirect_valid) |=>
            (out_valid && $stable(out_pc) && $stable(out_predict_taken)
             && $stable(out_predict_target)))
        else begin
            $error("packet changed while stalled by out_ready");
            failures++;
        end

    redirect_flushes: assert property (@(posedge clk) disable iff (reset)
        redirect_valid |=> !out_valid)
        else begin
            $error("out_valid high in the cycle after a redirect");
            failures++;
        end

endmodule

bind fetch_top fetch_checker protocol_check (
    .clk                (clk),
    .reset              (reset),
    .redirect_valid     (redirect_valid),
    .out_valid          (out_valid),
    .out_ready          (out_ready),
    .out_pc             (out_pc),
    .out_predict_taken  (out_predict_taken),
    .out_predict_target (out_predict_target)
);

// File: source/fetch_top.sv
module fetch_top (
    input  logic             clk,
    input  logic             reset,
    input  logic             redirect_valid,
    input  fetch_pkg::addr_t redirect_pc,
    input  logic             resolve_valid,
    input  fetch_pkg::addr_t resolve_pc,
    input  logic             resolve_taken,
    input  fetch_pkg::addr_t resolve_target,
    output logic             out_valid,
    input  logic             out_ready,
    output fetch_pkg::addr_t out_pc,
    output logic             out_predict_taken,
    output fetch_pkg::addr_t out_predict_target
);
    import fetch_pkg::*;

    addr_t         lookup_pc;
    logic          predict_taken;
    addr_t         predict_target;
    logic          push_valid;
    logic          push_ready;
    fetch_packet_t push_packet;
    fetch_packet_t pop_packet;

    resolve_if resolve_bus ();

    assign resolve_bus.valid  = resolve_valid;
    assign resolve_bus.pc     = resolve_pc;
    assign resolve_bus.taken  = resolve_taken;
    assign resolve_bus.target = resolve_target;

    branch_predictor predictor (
        .clk            (clk),
        .reset          (reset),
        .resolve        (resolve_bus.sink),
        .lookup_pc      (lookup_pc),
        .predict_taken  (predict_taken),
        .predict_target (predict_target)
    );

    fetch_pc_gen pc_gen (
        .clk            (clk),
        .reset          (reset),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .lookup_pc      (lookup_pc),
        .predict_taken  (predict_taken),
        .predict_target (predict_target),
        .push_valid     (push_valid),
        .push_ready     (push_ready),
        .push_packet    (push_packet)
    );

    // a redirect drops everything still waiting for decode.
    fetch_queue queue (
        .clk         (clk),
        .reset       (reset),
        .flush       (redirect_valid),
        .push_valid  (push_valid),
        .push_ready  (push_ready),
        .push_packet (push_packet),
        .pop_valid   (out_valid),
        .pop_ready   (out_ready),
        .pop_packet  (pop_packet)
    );

    assign out_pc             = pop_packet.pc;
    assign out_predict_taken  = pop_packet.predict_taken;
    assign out_predict_target = pop_packet.predict_target;

endmodule

// File: source/fetch_queue.sv
`include "fetch_defs.svh"

module fetch_queue (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     flush,
    input  logic                     push_valid,
    output logic                     push_ready,
    input  fetch_pkg::fetch_packet_t push_packet,
    output logic                     pop_valid,
    input  logic                     pop_ready,
    output fetch_pkg::fetch_packet_t pop_packet
);
    import fetch_pkg::*;

    localparam int DEPTH = `FETCH_QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    fetch_packet_t slots [DEPTH];

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             push_fire;
    logic             pop_fire;

    // wraps for any depth, not only powers of two.
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + PTR_W'(1);
    endfunction

    assign full       = (count == CNT_W'(DEPTH));
    assign push_ready = !full || pop_ready;  // a pop frees a slot this cycle.
    assign pop_valid  = (count != '0);
    assign pop_packet = slots[head];

    assign push_fire = push_valid && push_ready && !flush;
    assign pop_fire  = pop_valid && pop_ready && !flush;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pointers and count
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push_fire) begin
                tail <= next_ptr(tail);
            end
            if (pop_fire) begin
                head <= next_ptr(head);
            end
            case ({push_fire, pop_fire})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;  // both or neither.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_fire) begin
            slots[tail] <= push_packet;
        end
    end

endmodule

// File: source/fetch_pc_gen.sv
`include "fetch_defs.svh"

module fetch_pc_gen (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     redirect_valid,
    input  fetch_pkg::addr_t         redirect_pc,
    output fetch_pkg::addr_t         lookup_pc,
    input  logic                     predict_taken,
    input  fetch_pkg::addr_t         predict_target,
    output logic                     push_valid,
    input  logic                     push_ready,
    output fetch_pkg::fetch_packet_t push_packet
);
    import fetch_pkg::*;

    addr_t fetch_pc;
    logic  push_fire;

    assign lookup_pc = fetch_pc;

    // the packet in flight during a redirect is wrong path.
    assign push_valid = !redirect_valid;
    assign push_fire  = push_valid && push_ready;

    assign push_packet = '{
        pc:             fetch_pc,
        predict_taken:  predict_taken,
        predict_target: predict_target
    };

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pc register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_pc <= `RESET_PC;
        end else if (redirect_valid) begin
            fetch_pc <= redirect_pc;  // backend wins over prediction.
        end else if (push_fire) begin
            fetch_pc <= predict_target;
        end
        // holds while the queue is full.
    end

endmodule

// File: branch_predictor/branch_predictor.sv
`include "fetch_defs.svh"

module branch_predictor (
    input  logic             clk,
    input  logic             reset,
    resolve_if.sink          resolve,
    input  fetch_pkg::addr_t lookup_pc,
    output logic             predict_taken,
    output fetch_pkg::addr_t predict_target
);
    import fetch_pkg::*;

    localparam int PHT_IDX_W = $clog2(`PRED_TABLE_SIZE);
    localparam int BTB_IDX_W = $clog2(`BTB_SIZE);

    counter_t   pht [`PRED_TABLE_SIZE];
    btb_entry_t btb [`BTB_SIZE];

    logic [PHT_IDX_W-1:0] lookup_pht_idx;
    logic [BTB_IDX_W-1:0] lookup_btb_idx;
    logic [PHT_IDX_W-1:0] train_pht_idx;
    logic [BTB_IDX_W-1:0] train_btb_idx;

    counter_t   lookup_count;
    btb_entry_t lookup_entry;
    counter_t   train_count;

    // both tables skip the two byte-offset bits.
    assign lookup_pht_idx = lookup_pc[PHT_IDX_W+1:2];
    assign lookup_btb_idx = lookup_pc[BTB_IDX_W+1:2];
    assign train_pht_idx  = resolve.pc[PHT_IDX_W+1:2];
    assign train_btb_idx  = resolve.pc[BTB_IDX_W+1:2];

    assign lookup_count = pht[lookup_pht_idx];
    assign lookup_entry = btb[lookup_btb_idx];
    assign train_count  = pht[train_pht_idx];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lookup
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        predict_taken  = (lookup_count >= WEAK_TAKEN);
        predict_target = lookup_pc + INST_BYTES;
        // an aliased entry from another pc must not steer fetch.
        if (predict_taken && (lookup_entry.tag == lookup_pc)) begin
            predict_target = lookup_entry.target;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // training
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `PRED_TABLE_SIZE; i++) begin
                pht[i] <= COUNTER_INIT;
            end
            for (int j = 0; j < `BTB_SIZE; j++) begin
                btb[j] <= '0;
            end
        end else if (resolve.valid) begin
            if (resolve.taken) begin
                if (train_count != COUNTER_MAX) begin
                    pht[train_pht_idx] <= train_count + counter_t'(1);
                end
                btb[train_btb_idx] <= '{tag: resolve.pc, target: resolve.target};
            end else if (train_count != COUNTER_MIN) begin
                pht[train_pht_idx] <= train_count - counter_t'(1);  // target kept.
            end
        end
    end

endmodule

// File: common/resolve_if.sv
// at most one resolved branch from commit per cycle.
interface resolve_if;
    import fetch_pkg::*;

    logic  valid;
    addr_t pc;
    logic  taken;
    addr_t target;

    modport source (
        output valid,
        output pc,
        output taken,
        output target
    );

    // the predictor always accepts, so there is no ready.
    modport sink (
        input valid,
        input pc,
        input taken,
        input target
    );

endinterface

// File: common/fetch_pkg.sv
`include "fetch_defs.svh"

package fetch_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // basic types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [`XLEN-1:0] addr_t;

    // 0,1 lean not taken, 2,3 lean taken.
    typedef logic [1:0] counter_t;

    localparam counter_t COUNTER_MIN  = 2'd0;
    localparam counter_t COUNTER_INIT = 2'd1;  // weakly not taken.
    localparam counter_t WEAK_TAKEN   = 2'd2;
    localparam counter_t COUNTER_MAX  = 2'd3;

    // fall-through step of one 32-bit instruction per packet.
    localparam addr_t INST_BYTES = `XLEN'd4;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // structured types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the whole pc is kept as the tag.
    typedef struct packed {
        addr_t tag;
        addr_t target;
    } btb_entry_t;

    // one packet per fetched pc, with the guess made for it.
    typedef struct packed {
        addr_t pc;
        logic  predict_taken;
        addr_t predict_target;  // next pc the generator moved to.
    } fetch_packet_t;

endpackage

// File: common/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// address width of the fetch path.
`define XLEN 32

// number of 2-bit counters in the direction table.
`define PRED_TABLE_SIZE 64

// number of tagged target buffer entries.
`define BTB_SIZE 16

// slots between the pc generator and decode.
`define FETCH_QUEUE_DEPTH 4

// first fetch address out of reset.
`define RESET_PC 32'h0000_1000

`endif
